// File: verilog/lifo_macros.svh
`ifndef LIFO_MACROS_SVH
`define LIFO_MACROS_SVH

// Payload width in bits
`define LIFO_WIDTH 8

// Number of stack entries, 2 or more
`define LIFO_DEPTH 4

// Ceiling log2 of a constant expression
// Good for arguments up to 8192
`define CLOG2(x) \
  (((x) <= 1) ? 0 : ((x) <= 2) ? 1 : ((x) <= 4) ? 2 : ((x) <= 8) ? 3 : \
   ((x) <= 16) ? 4 : ((x) <= 32) ? 5 : ((x) <= 64) ? 6 : ((x) <= 128) ? 7 : \
   ((x) <= 256) ? 8 : ((x) <= 512) ? 9 : ((x) <= 1024) ? 10 : \
   ((x) <= 2048) ? 11 : ((x) <= 4096) ? 12 : 13)

// RAM address width, never narrower than one bit
`define LIFO_ADDR_WIDTH \
  ((`CLOG2(`LIFO_DEPTH) < 1) ? 1 : `CLOG2(`LIFO_DEPTH))

`endif

// File: verilog/lifo_pkg.sv
`include "lifo_macros.svh"

package lifo_pkg;

  // One stack word as seen on both ports
  typedef logic [`LIFO_WIDTH-1:0] lifo_data_t;

  // Index into the storage array
  typedef logic [`LIFO_ADDR_WIDTH-1:0] lifo_addr_t;

  // Stack pointer, counts stored entries
  // One extra bit so a full stack reads as LIFO_DEPTH
  typedef logic [`LIFO_ADDR_WIDTH:0] lifo_count_t;

endpackage

// File: verilog/lifo_memory_if.sv
`timescale 1ns/1ps

interface lifo_memory_if #(
  // Payload carried on both data lanes
  parameter type data_t = lifo_pkg::lifo_data_t
);

  // Write port, driven by the controller
  logic                 write_enable;
  lifo_pkg::lifo_addr_t write_address;
  data_t                write_data;

  // Read port request, driven by the controller
  logic                 read_enable;
  lifo_pkg::lifo_addr_t read_address;

  // Read result, driven by the RAM
  data_t                read_data;

  // Controller side
  modport controller (
    output write_enable,
    output write_address,
    output write_data,
    output read_enable,
    output read_address,
    input  read_data
  );

  // Storage side
  modport ram (
    input  write_enable,
    input  write_address,
    input  write_data,
    input  read_enable,
    input  read_address,
    output read_data
  );

endinterface

// File: verilog/simple_dual_port_ram.sv
`timescale 1ns/1ps
`include "lifo_macros.svh"

module simple_dual_port_ram #(
  parameter type data_t = lifo_pkg::lifo_data_t,
  parameter int  DEPTH  = `LIFO_DEPTH
) (
  input logic        clock,
  lifo_memory_if.ram mem
);

  // Storage array, no reset on the payload
  data_t storage [DEPTH];

  // Write port
  // One word per rising edge when enabled
  always_ff @(posedge clock) begin
    if (mem.write_enable) begin
      storage[mem.write_address] <= mem.write_data;
    end
  end

  // Read port
  // Purely combinational, so the top word is visible in the same cycle
  always_comb begin
    if (mem.read_enable) begin
      mem.read_data = storage[mem.read_address];
    end else begin
      // Nothing valid to show
      mem.read_data = '0;
    end
  end

  // Address from the controller must land inside the array
  write_address_in_range : assert property (
    @(posedge clock) mem.write_enable |-> (int'(mem.write_address) < DEPTH)
  ) else $error("RAM write to address %0d beyond depth %0d",
                mem.write_address, DEPTH);

endmodule

// File: verilog/lifo_controller.sv
`timescale 1ns/1ps
`include "lifo_macros.svh"

module lifo_controller (
  input  logic                     clock,
  input  logic                     rst,
  // Write side
  input  lifo_pkg::lifo_data_t     write_data,
  input  logic                     write_valid,
  output logic                     write_ready,
  // Read side
  output lifo_pkg::lifo_data_t     read_data,
  output logic                     read_valid,
  input  logic                     read_ready,
  // Level flags
  output logic                     full,
  output logic                     empty,
  // Storage
  lifo_memory_if.controller        mem
);

  // Pointer value of a full stack
  localparam lifo_pkg::lifo_count_t DEPTH_COUNT = `LIFO_DEPTH;

  // Accepted transfers this cycle
  logic push;
  logic pop;

  // Entry count and its value after this edge
  lifo_pkg::lifo_count_t pointer;
  lifo_pkg::lifo_count_t pointer_next;

  // Address of the current top entry
  lifo_pkg::lifo_addr_t top_address;

  // Readiness comes from the flags only
  // Neither side waits on the other's valid
  assign write_ready = ~full;
  assign read_valid  = ~empty;

  // Handshakes
  assign push = write_valid & write_ready;
  assign pop  = read_valid & read_ready;

  // Next pointer
  always_comb begin
    case ({push, pop})
      // Lone push grows the stack
      2'b10:   pointer_next = pointer + 1'b1;
      // Lone pop shrinks it
      2'b01:   pointer_next = pointer - 1'b1;
      // Idle, or swap of the top entry
      default: pointer_next = pointer;
    endcase
  end

  // Pointer and flags, all on the RAM write edge
  always_ff @(posedge clock) begin
    if (rst) begin
      pointer <= '0;
      full    <= 1'b0;
      empty   <= 1'b1;
    end else begin
      pointer <= pointer_next;
      // Flags registered from the next count
      full    <= (pointer_next == DEPTH_COUNT);
      empty   <= (pointer_next == '0);
    end
  end

  // Top sits one below the pointer
  // Wraps when empty, but the read is disabled then
  assign top_address = lifo_pkg::lifo_addr_t'(pointer - 1'b1);

  // Write side of the RAM
  assign mem.write_enable  = push;
  assign mem.write_data    = write_data;
  // Simultaneous pop frees the top slot, so overwrite it
  assign mem.write_address = pop ? top_address : lifo_pkg::lifo_addr_t'(pointer);

  // Read side of the RAM
  assign mem.read_enable  = read_valid;
  assign mem.read_address = top_address;
  assign read_data        = mem.read_data;

  // Registered full flag agrees with the count at every push
  push_not_when_full : assert property (
    @(posedge clock) disable iff (rst)
    mem.write_enable |-> (pointer < DEPTH_COUNT)
  ) else $error("Push accepted with %0d entries stored", pointer);

  // Registered empty flag agrees with the count at every pop
  pop_not_when_empty : assert property (
    @(posedge clock) disable iff (rst)
    pop |-> (pointer != '0)
  ) else $error("Pop accepted on an empty stack");

  // Count stays within the storage
  pointer_in_range : assert property (
    @(posedge clock) disable iff (rst)
    pointer <= DEPTH_COUNT
  ) else $error("Stack pointer %0d past depth %0d", pointer, DEPTH_COUNT);

  // Pushed word comes back from the RAM as the new top one cycle later
  push_becomes_top : assert property (
    @(posedge clock) disable iff (rst)
    push |=> (read_valid && read_data == $past(write_data))
  ) else $error("Pushed word missing from top of stack");

endmodule

// File: verilog/valid_ready_lifo.sv
`timescale 1ns/1ps
`include "lifo_macros.svh"

module valid_ready_lifo (
  input  logic                   clock,
  input  logic                   rst,
  output logic                   full,
  output logic                   empty,
  // Write side
  input  logic [`LIFO_WIDTH-1:0] write_data,
  input  logic                   write_valid,
  output logic                   write_ready,
  // Read side
  output logic [`LIFO_WIDTH-1:0] read_data,
  output logic                   read_valid,
  input  logic                   read_ready
);

  // Link between controller and storage
  lifo_memory_if #(
    .data_t ( lifo_pkg::lifo_data_t )
  ) mem_bus ();

  // Handshake, pointer and flags
  lifo_controller controller (
    .clock       ( clock       ),
    .rst         ( rst         ),
    // Write side
    .write_data  ( write_data  ),
    .write_valid ( write_valid ),
    .write_ready ( write_ready ),
    // Read side
    .read_data   ( read_data   ),
    .read_valid  ( read_valid  ),
    .read_ready  ( read_ready  ),
    // Level flags
    .full        ( full        ),
    .empty       ( empty       ),
    // Storage port
    .mem         ( mem_bus.controller )
  );

  // Stack storage
  // Runs on the system clock
  simple_dual_port_ram #(
    .data_t ( lifo_pkg::lifo_data_t ),
    .DEPTH  ( `LIFO_DEPTH           )
  ) memory (
    .clock ( clock       ),
    .mem   ( mem_bus.ram )
  );

endmodule

// File: bench/valid_ready_lifo_tb.sv
`timescale 1ns/1ps
`include "lifo_macros.svh"

module valid_ready_lifo_tb;

  localparam int CLOCK_PERIOD    = 20;
  localparam int DIRECTED_CYCLES = 80;
  localparam int RANDOM_CYCLES   = 400;
  // Twice the expected run length
  localparam int TIMEOUT_NS = (DIRECTED_CYCLES + RANDOM_CYCLES + 20) * CLOCK_PERIOD * 2;

  logic                 clock;
  logic                 rst;
  logic                 full;
  logic                 empty;
  lifo_pkg::lifo_data_t write_data;
  logic                 write_valid;
  logic                 write_ready;
  lifo_pkg::lifo_data_t read_data;
  logic                 read_valid;
  logic                 read_ready;

  // Reference stack, top at the back
  lifo_pkg::lifo_data_t model[$];
  lifo_pkg::lifo_data_t pushed[`LIFO_DEPTH];

  int          error_count = 0;
  int          check_count = 0;
  logic [31:0] lfsr_state  = 32'h0d127bc9;

  valid_ready_lifo dut (
    .clock       ( clock       ),
    .rst         ( rst         ),
    .full        ( full        ),
    .empty       ( empty       ),
    .write_data  ( write_data  ),
    .write_valid ( write_valid ),
    .write_ready ( write_ready ),
    .read_data   ( read_data   ),
    .read_valid  ( read_valid  ),
    .read_ready  ( read_ready  )
  );

  // Free running clock
  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic random_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return lfsr_state[0];
  endfunction

  // One LFSR step per payload bit
  function automatic lifo_pkg::lifo_data_t random_word();
    lifo_pkg::lifo_data_t w;
    for (int b = 0; b < `LIFO_WIDTH; b++) begin
      w[b] = random_bit();
    end
    return w;
  endfunction

  // Expected read_data, zero while nothing is stored
  function automatic lifo_pkg::lifo_data_t model_top();
    if (model.size() == 0) begin
      return '0;
    end
    return model[$];
  endfunction

  task automatic check_data(input lifo_pkg::lifo_data_t actual,
                            input lifo_pkg::lifo_data_t expected, input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string name);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, name, actual, expected);
    end
  endtask

  // Compare 2 ns before each edge, then advance the model for that edge
  initial begin : compare_outputs
    logic exp_full;
    logic exp_empty;
    logic do_push;
    logic do_pop;
    forever begin
      @(posedge clock);
      #(CLOCK_PERIOD - 2);
      if (rst) begin
        model.delete();
      end else begin
        exp_full  = (model.size() == `LIFO_DEPTH);
        exp_empty = (model.size() == 0);
        check_flag(full, exp_full, "full");
        check_flag(empty, exp_empty, "empty");
        check_flag(write_ready, ~exp_full, "write_ready");
        check_flag(read_valid, ~exp_empty, "read_valid");
        if (!exp_empty) begin
          check_data(read_data, model_top(), "read_data");
        end
        // Handshakes from the rules, not from the DUT
        do_push = write_valid && !exp_full;
        do_pop  = read_ready && !exp_empty;
        if (do_pop) begin
          void'(model.pop_back());
        end
        if (do_push) begin
          model.push_back(write_data);
        end
      end
    end
  end

  // Hold valid until the stack accepts
  task automatic push_word(input lifo_pkg::lifo_data_t w);
    write_data  = w;
    write_valid = 1'b1;
    read_ready  = 1'b0;
    while (!write_ready) begin
      @(posedge clock);
      #2;
    end
    @(posedge clock);
    #2;
    write_valid = 1'b0;
  endtask

  // Wait for data, compare it, then pop it
  task automatic pop_word(input lifo_pkg::lifo_data_t expected, input string what);
    write_valid = 1'b0;
    read_ready  = 1'b1;
    while (!read_valid) begin
      @(posedge clock);
      #2;
    end
    check_data(read_data, expected, what);
    @(posedge clock);
    #2;
    read_ready = 1'b0;
  endtask

  initial begin : stimulus
    rst         = 1'b1;
    write_data  = '0;
    write_valid = 1'b0;
    read_ready  = 1'b0;
    repeat (3) @(posedge clock);
    #2;
    rst = 1'b0;

    // State right after reset
    check_flag(empty, 1'b1, "empty after reset");
    check_flag(full, 1'b0, "full after reset");
    check_flag(read_valid, 1'b0, "read_valid after reset");
    check_flag(write_ready, 1'b1, "write_ready after reset");

    // Fill the stack
    for (int i = 0; i < `LIFO_DEPTH; i++) begin
      pushed[i] = lifo_pkg::lifo_data_t'(i * 17 + 5);
      push_word(pushed[i]);
    end
    check_flag(full, 1'b1, "full after fill");
    check_flag(write_ready, 1'b0, "write_ready after fill");

    // Extra push must bounce off
    write_data  = 8'hee;
    write_valid = 1'b1;
    repeat (2) @(posedge clock);
    #2;
    write_valid = 1'b0;
    check_flag(full, 1'b1, "full after ignored push");
    check_data(read_data, pushed[`LIFO_DEPTH-1], "top after ignored push");

    // Drain in reverse order
    for (int i = `LIFO_DEPTH - 1; i >= 0; i--) begin
      pop_word(pushed[i], "pop order");
    end
    check_flag(empty, 1'b1, "empty after drain");

    // Swap the top with a simultaneous push and pop
    push_word(8'h1a);
    push_word(8'h2b);
    write_data  = 8'h3c;
    write_valid = 1'b1;
    read_ready  = 1'b1;
    check_data(read_data, 8'h2b, "old top during swap");
    @(posedge clock);
    #2;
    write_valid = 1'b0;
    read_ready  = 1'b0;
    check_data(read_data, 8'h3c, "new top after swap");
    check_flag(empty, 1'b0, "empty after swap");
    pop_word(8'h3c, "swapped word");
    pop_word(8'h1a, "bottom word after swap");
    check_flag(empty, 1'b1, "empty after swap drain");

    // Random traffic, checker does the comparing
    repeat (RANDOM_CYCLES) begin
      write_valid = random_bit();
      read_ready  = random_bit();
      write_data  = random_word();
      @(posedge clock);
      #2;
    end
    write_valid = 1'b0;

    // Empty out, then load two words for the hold test
    read_ready = 1'b1;
    while (!empty) begin
      @(posedge clock);
      #2;
    end
    read_ready = 1'b0;
    push_word(8'h5a);
    push_word(8'ha5);

    // Reader stalls, top word and valid must hold
    repeat (5) begin
      @(posedge clock);
      #2;
      check_data(read_data, 8'ha5, "read_data under back-pressure");
      check_flag(read_valid, 1'b1, "read_valid under back-pressure");
    end

    repeat (2) @(posedge clock);
    #2;
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Hang guard
  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Run timed out after %0d ns without reaching the end of the tests", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

endmodule

// File: valid_ready_lifo.f
+incdir+verilog
verilog/lifo_pkg.sv
verilog/lifo_memory_if.sv
verilog/simple_dual_port_ram.sv
verilog/lifo_controller.sv
verilog/valid_ready_lifo.sv
bench/valid_ready_lifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the LIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

# Compile with assertions enabled
verilator --binary --timing --assert -f valid_ready_lifo.f \
  --top-module valid_ready_lifo_tb -o valid_ready_lifo_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Run and keep the output for the verdict
output=$(./obj_dir/valid_ready_lifo_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict comes from the printed result line
if printf '%s\n' "$output" | grep -qx "Test passed"; then
  exit 0
else
  echo "Pass line not found in simulation output"
  exit 1
fi
